/* filelist.f */
source/rvfi_mon_pkg.sv
source/monitor_if.sv
source/commit_decoder.sv
source/termination_watch.sv
source/trace_record_queue.sv
source/rvfi_monitor_top.sv
test/rvfi_monitor_sva.sv
test/rvfi_monitor_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the commit monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=rvfi_monitor_tb

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module "$TOP" -Mdir obj_dir -f filelist.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

/* test/rvfi_monitor_tb.sv */
// Testbench for the commit-stream monitor with table stimulus and a credit consumer model
module rvfi_monitor_tb
  import rvfi_mon_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [XLEN-1:0] TOHOST         = 32'h8000_1000;
  localparam int unsigned     TIMEOUT_CYCLES = 2000;
  localparam int unsigned     QUEUE_DEPTH    = 4;
  localparam int unsigned     CREDITS        = 2;
  localparam logic [31:0]     SEED           = 32'h96a6_c40e;
  localparam logic [XLEN-1:0] PC0            = 32'h8000_0000;

  // One commit and the record it should produce
  typedef struct packed {
    logic                  trap;
    logic [INSN_W-1:0]     insn;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       cause;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [3:0]            rmask;
    logic [3:0]            wmask;
    logic [XLEN-1:0]       wdata;
    rec_kind_e             kind;
    logic [INSN_W-1:0]     e_insn;
    logic [XLEN-1:0]       e_data;
    logic [XLEN-1:0]       e_addr;
    logic                  e_last;
    logic                  burst;
    logic                  out;
    logic                  intr;
  } row_t;

  logic clk_i;
  logic rst_ni;
  logic commit_valid_i;
  logic commit_trap_i;
  logic commit_intr_i;
  logic [INSN_W-1:0] commit_insn_i;
  logic [XLEN-1:0] commit_pc_i;
  logic [XLEN-1:0] commit_cause_i;
  logic [REG_ADDR_W-1:0] commit_rd_addr_i;
  logic [XLEN-1:0] commit_rd_wdata_i;
  logic [XLEN-1:0] commit_mem_addr_i;
  logic [3:0] commit_mem_rmask_i;
  logic [3:0] commit_mem_wmask_i;
  logic [XLEN-1:0] commit_mem_wdata_i;
  logic trace_valid_o;
  rec_kind_e trace_kind_o;
  logic [XLEN-1:0] trace_pc_o;
  logic [INSN_W-1:0] trace_insn_o;
  logic [REG_ADDR_W-1:0] trace_rd_addr_o;
  logic [XLEN-1:0] trace_data_o;
  logic [XLEN-1:0] trace_addr_o;
  logic trace_intr_o;
  logic trace_last_o;
  logic credit_return_i;
  logic overflow_o;
  logic [XLEN-1:0] end_of_test_o;

  row_t        rows[$];
  row_t        exp_q[$];
  int          credit_due[$];
  int          n_checks = 0;
  int          n_errors = 0;
  int          cycle_cnt = 0;
  int          max_cycles = 0;
  int          outstanding = 0;
  int          sent_total = 0;
  logic        hold_credits = 1'b0;
  logic [31:0] gap_lfsr = SEED;
  logic [31:0] credit_lfsr = SEED;

  rvfi_monitor_top #(
    .TOHOST_ADDR    (TOHOST),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .QUEUE_DEPTH    (QUEUE_DEPTH),
    .CREDITS        (CREDITS)
  ) UUT (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Run limit covers the table rows and the long timeout test
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_kind(input string what, input rec_kind_e got, input rec_kind_e expected);
    n_checks++;
    if (got !== expected) begin
      n_errors++;
      $display("Mismatch at %0t: %s expected %s got %s", $time, what, expected.name(),
               got.name());
    end
  endtask

  task automatic check_word(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] expected);
    n_checks++;
    if (got !== expected) begin
      n_errors++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, what, expected, got);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic expected);
    n_checks++;
    if (got !== expected) begin
      n_errors++;
      $display("Mismatch at %0t: %s expected %b got %b", $time, what, expected, got);
    end
  endtask

  // Fibonacci LFSR with taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(inout logic [31:0] st, input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_next(st);
      v = v * 2 + (st[0] ? 1 : 0);
    end
  endtask

  task automatic add_row(input logic trap, input logic [31:0] insn, pc, cause,
                         input logic [4:0] rd, input logic [31:0] rd_wdata, mem_addr,
                         input logic [3:0] rmask, wmask, input logic [31:0] wdata,
                         input rec_kind_e kind, input logic [31:0] e_insn, e_data, e_addr,
                         input logic e_last, burst, out, intr);
    rows.push_back({trap, insn, pc, cause, rd, rd_wdata, mem_addr, rmask, wmask, wdata,
                    kind, e_insn, e_data, e_addr, e_last, burst, out, intr});
  endtask

  task automatic build_table();
    add_row(0, 32'h0070_0293, PC0, 0, 5'd5, 32'd7, 0, 4'h0, 4'h0, 0,
            REC_INT, 32'h0070_0293, 32'd7, 0, 0, 0, 1, 0);
    add_row(0, 32'h0002_a303, PC0 + 4, 0, 5'd6, 32'hdead_beef, 32'h8000_0100, 4'hf, 4'h0, 0,
            REC_INT, 32'h0002_a303, 32'hdead_beef, 32'h8000_0100, 0, 0, 1, 0);
    add_row(0, 32'h0031_00d3, PC0 + 8, 0, 5'd1, 32'h3f80_0000, 0, 4'h0, 4'h0, 0,
            REC_FP, 32'h0031_00d3, 32'h3f80_0000, 0, 0, 0, 1, 0);
    // feq.s lands in an integer register
    add_row(0, 32'ha020_a3d3, PC0 + 12, 0, 5'd7, 32'd1, 0, 4'h0, 4'h0, 0,
            REC_INT, 32'ha020_a3d3, 32'd1, 0, 0, 0, 1, 0);
    // c.flw with junk in the upper half
    add_row(0, 32'habcd_61c8, PC0 + 16, 0, 5'd10, 32'h4049_0fdb, 32'h8000_0104, 4'hf, 4'h0, 0,
            REC_FP, 32'h0000_61c8, 32'h4049_0fdb, 0, 0, 0, 1, 0);
    add_row(0, 32'h0062_a423, PC0 + 18, 0, 5'd0, 0, 32'h8000_0108, 4'h0, 4'hf, 32'hdead_beef,
            REC_STORE, 32'h0062_a423, 32'hdead_beef, 32'h8000_0108, 0, 0, 1, 0);
    add_row(0, 32'h0000_0463, PC0 + 22, 0, 5'd0, 0, 0, 4'h0, 4'h0, 0,
            REC_PLAIN, 32'h0000_0463, 0, 0, 0, 0, 1, 0);
    add_row(1, 32'hffff_ffff, PC0 + 26, 32'd2, 5'd0, 0, 0, 4'h0, 4'h0, 0,
            REC_TRAP, 32'hffff_ffff, 32'd2, 0, 0, 0, 1, 0);
    // First instruction of the trap handler carries intr
    add_row(0, 32'h0062_a023, PC0 + 30, 0, 5'd0, 0, TOHOST, 4'h0, 4'hf, 32'h1,
            REC_STORE, 32'h0062_a023, 32'h1, TOHOST, 1, 0, 1, 1);
    // Second tohost store after the end is already recorded
    add_row(0, 32'h0062_a023, PC0 + 34, 0, 5'd0, 0, TOHOST, 4'h0, 4'hf, 32'h3,
            REC_STORE, 32'h0062_a023, 32'h3, TOHOST, 0, 0, 1, 0);
    for (int i = 0; i < 8; i++) begin
      add_row(0, 32'h0010_0093, 32'h8000_0200 + 32'(4 * i), 0, 5'd1, 32'(i), 0, 4'h0, 4'h0, 0,
              REC_INT, 32'h0010_0093, 32'(i), 0, 0, 1, i < QUEUE_DEPTH + CREDITS, 0);
    end
  endtask

  task automatic idle_commit();
    commit_valid_i = 1'b0;
    commit_trap_i  = 1'b0;
  endtask

  task automatic drive_row(input row_t r);
    @(negedge clk_i);
    commit_valid_i     = !r.trap;
    commit_trap_i      = r.trap;
    commit_intr_i      = r.intr;
    commit_insn_i      = r.insn;
    commit_pc_i        = r.pc;
    commit_cause_i     = r.cause;
    commit_rd_addr_i   = r.rd;
    commit_rd_wdata_i  = r.rd_wdata;
    commit_mem_addr_i  = r.mem_addr;
    commit_mem_rmask_i = r.rmask;
    commit_mem_wmask_i = r.wmask;
    commit_mem_wdata_i = r.wdata;
    if (r.out) begin
      exp_q.push_back(r);
    end
  endtask

  // Called at a falling edge or at time zero
  task automatic apply_reset();
    rst_ni = 1'b0;
    idle_commit();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic wait_drained(input int settle);
    while (exp_q.size() != 0 || outstanding != 0) begin
      @(negedge clk_i);
    end
    repeat (settle) @(negedge clk_i);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s: %0d errors", name, n_errors - errs_before);
  endtask

  // Consumer model that compares records and hands credits back after a random delay
  task automatic run_consumer();
    int   delay;
    int   errs_before;
    row_t exp_row;
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        credit_due.delete();
        outstanding = 0;
        credit_return_i = 1'b0;
      end else begin
        if (trace_valid_o === 1'b1) begin
          sent_total++;
          outstanding++;
          if (exp_q.size() == 0) begin
            n_errors++;
            $display("Unexpected record at %0t: pc %h arrived with none expected",
                     $time, trace_pc_o);
          end else begin
            exp_row = exp_q.pop_front();
            errs_before = n_errors;
            check_word("pc", trace_pc_o, exp_row.pc);
            check_kind("kind", trace_kind_o, exp_row.kind);
            check_word("insn", trace_insn_o, exp_row.e_insn);
            check_word("rd_addr", XLEN'(trace_rd_addr_o), XLEN'(exp_row.rd));
            check_word("data", trace_data_o, exp_row.e_data);
            check_word("addr", trace_addr_o, exp_row.e_addr);
            check_flag("intr", trace_intr_o, exp_row.intr);
            check_flag("last", trace_last_o, exp_row.e_last);
            check_flag("outstanding within credits", outstanding <= CREDITS, 1'b1);
            $display("Record pc %h kind %s: %0d errors", exp_row.pc, exp_row.kind.name(),
                     n_errors - errs_before);
          end
          draw_bits(credit_lfsr, 2, delay);
          credit_due.push_back(cycle_cnt + delay);
        end
        credit_return_i = 1'b0;
        if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cycle_cnt) begin
          void'(credit_due.pop_front());
          credit_return_i = 1'b1;
          outstanding--;
        end
      end
    end
  endtask

  initial begin
    int gap;
    int k;
    int errs_before;
    int sent_before;
    rst_ni             = 1'b0;
    commit_valid_i     = 1'b0;
    commit_trap_i      = 1'b0;
    commit_intr_i      = 1'b0;
    commit_insn_i      = '0;
    commit_pc_i        = '0;
    commit_cause_i     = '0;
    commit_rd_addr_i   = '0;
    commit_rd_wdata_i  = '0;
    commit_mem_addr_i  = '0;
    commit_mem_rmask_i = '0;
    commit_mem_wmask_i = '0;
    commit_mem_wdata_i = '0;
    credit_return_i    = 1'b0;
    build_table();
    max_cycles = 40 * rows.size() + 200 + TIMEOUT_CYCLES;
    fork
      run_consumer();
    join_none
    apply_reset();

    // Classification, order and tohost end with random gaps
    errs_before = n_errors;
    foreach (rows[i]) begin
      if (!rows[i].burst) begin
        drive_row(rows[i]);
        if (rows[i].e_last) begin
          @(negedge clk_i);
          idle_commit();
          @(negedge clk_i);
          check_word("end_of_test one cycle after tohost", end_of_test_o, '0);
          @(negedge clk_i);
          check_word("end_of_test two cycles after tohost", end_of_test_o, 32'h1);
        end
        draw_bits(gap_lfsr, 2, gap);
        repeat (gap) begin
          @(negedge clk_i);
          idle_commit();
        end
      end
    end
    @(negedge clk_i);
    idle_commit();
    wait_drained(6);
    check_word("end_of_test held after second tohost", end_of_test_o, 32'h1);
    report_test("classification, order and tohost", errs_before);

    // Back-to-back burst with credit returns withheld
    errs_before = n_errors;
    check_flag("overflow before burst", overflow_o, 1'b0);
    hold_credits = 1'b1;
    sent_before = sent_total;
    foreach (rows[i]) begin
      if (rows[i].burst) begin
        drive_row(rows[i]);
      end
    end
    @(negedge clk_i);
    idle_commit();
    repeat (8) @(negedge clk_i);
    check_flag("overflow after burst", overflow_o, 1'b1);
    check_word("records sent on held credits", sent_total - sent_before, CREDITS);
    hold_credits = 1'b0;
    wait_drained(10);
    check_flag("overflow held", overflow_o, 1'b1);
    report_test("overflow", errs_before);

    // Timeout with no tohost store after a fresh reset
    errs_before = n_errors;
    apply_reset();
    check_word("end_of_test after reset", end_of_test_o, '0);
    check_flag("overflow after reset", overflow_o, 1'b0);
    k = 0;
    while (end_of_test_o !== '1) begin
      @(negedge clk_i);
      k++;
    end
    check_flag("timeout after limit", k > TIMEOUT_CYCLES, 1'b1);
    check_flag("timeout within two cycles", k < TIMEOUT_CYCLES + 3, 1'b1);
    report_test("timeout", errs_before);

    check_word("records never sent", exp_q.size(), 0);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* test/rvfi_monitor_sva.sv */
// Bound assertions on the trace queue credit accounting and sticky overflow flag
module rvfi_monitor_sva #(
  parameter int unsigned CREDITS = 2,
  parameter int unsigned CRED_W  = 2
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              trace_valid_i,
  input logic              credit_return_i,
  input logic [CRED_W-1:0] credit_i,
  input logic              overflow_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int held_q;

  // Credits held by the queue, counted from the output handshake alone
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      held_q <= CREDITS;
    end else begin
      held_q <= held_q + int'(credit_return_i) - int'(trace_valid_i);
    end
  end

  // A record on the output always consumes a held credit
  no_send_without_credit: assert property (
    @(posedge clk_i) disable iff (!rst_ni) trace_valid_i |-> (held_q > 0)
  ) else $error("trace record sent while no credit was held");

  // Returned credits never exceed what was granted
  credit_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) credit_i <= CRED_W'(CREDITS)
  ) else $error("credit count above the granted number");

  // Only a reset clears the overflow flag
  overflow_sticky: assert property (
    @(posedge clk_i) (overflow_i && rst_ni) |=> overflow_i
  ) else $error("overflow flag cleared without a reset");

endmodule

bind trace_record_queue rvfi_monitor_sva #(
  .CREDITS (CREDITS),
  .CRED_W  (CRED_W)
) u_sva (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .trace_valid_i   (trace_valid_o),
  .credit_return_i (credit_return_i),
  .credit_i        (credit_q),
  .overflow_i      (overflow_o)
);

/* source/rvfi_monitor_top.sv */
// Commit-stream monitor top level with decoder, end-of-test watcher and record queue
module rvfi_monitor_top
  import rvfi_mon_pkg::*;
#(
  parameter logic [XLEN-1:0] TOHOST_ADDR    = 32'h8000_1000,
  parameter int unsigned     TIMEOUT_CYCLES = 2000,
  parameter int unsigned     QUEUE_DEPTH    = 4,
  parameter int unsigned     CREDITS        = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  commit_valid_i,
  input  logic                  commit_trap_i,
  input  logic                  commit_intr_i,
  input  logic [INSN_W-1:0]     commit_insn_i,
  input  logic [XLEN-1:0]       commit_pc_i,
  input  logic [XLEN-1:0]       commit_cause_i,
  input  logic [REG_ADDR_W-1:0] commit_rd_addr_i,
  input  logic [XLEN-1:0]       commit_rd_wdata_i,
  input  logic [XLEN-1:0]       commit_mem_addr_i,
  input  logic [3:0]            commit_mem_rmask_i,
  input  logic [3:0]            commit_mem_wmask_i,
  input  logic [XLEN-1:0]       commit_mem_wdata_i,
  output logic                  trace_valid_o,
  output rec_kind_e             trace_kind_o,
  output logic [XLEN-1:0]       trace_pc_o,
  output logic [INSN_W-1:0]     trace_insn_o,
  output logic [REG_ADDR_W-1:0] trace_rd_addr_o,
  output logic [XLEN-1:0]       trace_data_o,
  output logic [XLEN-1:0]       trace_addr_o,
  output logic                  trace_intr_o,
  output logic                  trace_last_o,
  input  logic                  credit_return_i,
  output logic                  overflow_o,
  output logic [XLEN-1:0]       end_of_test_o
);

  commit_if commit_bus ();
  record_if rec_bus ();
  logic     end_hit;

  // Retirement port onto the commit bundle
  assign commit_bus.valid     = commit_valid_i;
  assign commit_bus.trap      = commit_trap_i;
  assign commit_bus.intr      = commit_intr_i;
  assign commit_bus.insn      = commit_insn_i;
  assign commit_bus.pc        = commit_pc_i;
  assign commit_bus.cause     = commit_cause_i;
  assign commit_bus.rd_addr   = commit_rd_addr_i;
  assign commit_bus.rd_wdata  = commit_rd_wdata_i;
  assign commit_bus.mem_addr  = commit_mem_addr_i;
  assign commit_bus.mem_rmask = commit_mem_rmask_i;
  assign commit_bus.mem_wmask = commit_mem_wmask_i;
  assign commit_bus.mem_wdata = commit_mem_wdata_i;

  commit_decoder u_decoder (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .commit (commit_bus.snk),
    .rec    (rec_bus.src)
  );

  termination_watch #(
    .TOHOST_ADDR    (TOHOST_ADDR),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_watch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .commit        (commit_bus.snk),
    .end_hit_o     (end_hit),
    .end_of_test_o (end_of_test_o)
  );

  trace_record_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .CREDITS     (CREDITS)
  ) u_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rec             (rec_bus.snk),
    .end_hit_i       (end_hit),
    .trace_valid_o   (trace_valid_o),
    .trace_kind_o    (trace_kind_o),
    .trace_pc_o      (trace_pc_o),
    .trace_insn_o    (trace_insn_o),
    .trace_rd_addr_o (trace_rd_addr_o),
    .trace_data_o    (trace_data_o),
    .trace_addr_o    (trace_addr_o),
    .trace_intr_o    (trace_intr_o),
    .trace_last_o    (trace_last_o),
    .credit_return_i (credit_return_i),
    .overflow_o      (overflow_o)
  );

endmodule

/* source/trace_record_queue.sv */
// Trace record queue that tags the end flag, buffers records and sends them on credits
module trace_record_queue
  import rvfi_mon_pkg::*;
#(
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter int unsigned CREDITS     = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  record_if.snk                 rec,
  input  logic                  end_hit_i,
  output logic                  trace_valid_o,
  output rec_kind_e             trace_kind_o,
  output logic [XLEN-1:0]       trace_pc_o,
  output logic [INSN_W-1:0]     trace_insn_o,
  output logic [REG_ADDR_W-1:0] trace_rd_addr_o,
  output logic [XLEN-1:0]       trace_data_o,
  output logic [XLEN-1:0]       trace_addr_o,
  output logic                  trace_intr_o,
  output logic                  trace_last_o,
  input  logic                  credit_return_i,
  output logic                  overflow_o
);

  localparam int unsigned PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_W  = $clog2(QUEUE_DEPTH + 1);
  localparam int unsigned CRED_W = $clog2(CREDITS + 1);

  // Field positions inside one stored entry
  localparam int unsigned ADDR_LSB = 2;
  localparam int unsigned DATA_LSB = ADDR_LSB + XLEN;
  localparam int unsigned RD_LSB   = DATA_LSB + XLEN;
  localparam int unsigned INSN_LSB = RD_LSB + REG_ADDR_W;
  localparam int unsigned PC_LSB   = INSN_LSB + INSN_W;
  localparam int unsigned KIND_LSB = PC_LSB + XLEN;
  localparam int unsigned ENTRY_W  = KIND_LSB + $bits(rec_kind_e);

  logic [ENTRY_W-1:0] mem_q [QUEUE_DEPTH];
  logic [ENTRY_W-1:0] wr_entry;
  logic [ENTRY_W-1:0] rd_entry;
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   cnt_q;
  logic [CRED_W-1:0]  credit_q;
  logic [CRED_W-1:0]  credit_avail;
  logic               full;
  logic               push;
  logic               pop;

  // End flag and record leave their stages on the same edge
  assign wr_entry = {rec.kind, rec.pc, rec.insn, rec.rd_addr, rec.data, rec.addr,
                     rec.intr, end_hit_i};
  assign rd_entry = mem_q[rd_ptr_q];

  assign full = (cnt_q == CNT_W'(QUEUE_DEPTH));
  assign push = rec.rec_valid && !full;

  // A sent record holds its credit until the cycle it is on the output
  assign credit_avail = credit_q + CRED_W'(credit_return_i) - CRED_W'(trace_valid_o);
  assign pop          = (cnt_q != '0) && (credit_avail != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      cnt_q         <= '0;
      credit_q      <= CRED_W'(CREDITS);
      trace_valid_o <= 1'b0;
      overflow_o    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q         <= cnt_q + CNT_W'(push) - CNT_W'(pop);
      credit_q      <= credit_avail;
      trace_valid_o <= pop;
      if (rec.rec_valid && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_entry;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      trace_kind_o    <= rec_kind_e'(rd_entry[KIND_LSB +: $bits(rec_kind_e)]);
      trace_pc_o      <= rd_entry[PC_LSB +: XLEN];
      trace_insn_o    <= rd_entry[INSN_LSB +: INSN_W];
      trace_rd_addr_o <= rd_entry[RD_LSB +: REG_ADDR_W];
      trace_data_o    <= rd_entry[DATA_LSB +: XLEN];
      trace_addr_o    <= rd_entry[ADDR_LSB +: XLEN];
      trace_intr_o    <= rd_entry[1];
      trace_last_o    <= rd_entry[0];
    end
  end

endmodule

/* source/termination_watch.sv */
// End-of-test watcher for tohost stores and the cycle timeout
module termination_watch
  import rvfi_mon_pkg::*;
#(
  parameter logic [XLEN-1:0] TOHOST_ADDR    = 32'h8000_1000,
  parameter int unsigned     TIMEOUT_CYCLES = 2000
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  commit_if.snk           commit,
  output logic            end_hit_o,
  output logic [XLEN-1:0] end_of_test_o
);

  localparam int unsigned CNT_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [CNT_W-1:0] TIMEOUT_LIMIT = CNT_W'(TIMEOUT_CYCLES);

  logic [CNT_W-1:0] cycle_q;
  logic             timeout;
  logic             recorded;
  logic             tohost_hit;
  logic             end_hit_q;
  logic [XLEN-1:0]  hit_data_q;
  logic [XLEN-1:0]  end_word_q;

  // Counter saturates at the limit, so it never wraps back under it
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else if (cycle_q != TIMEOUT_LIMIT) begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  assign timeout  = (cycle_q == TIMEOUT_LIMIT);
  assign recorded = end_hit_q || (end_word_q != '0);

  assign tohost_hit = commit.valid && (commit.mem_wmask != '0) &&
                      (commit.mem_addr == TOHOST_ADDR) &&
                      commit.mem_wdata[0] && !recorded;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      end_hit_q <= 1'b0;
    end else begin
      end_hit_q <= tohost_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tohost_hit) begin
      hit_data_q <= commit.mem_wdata;
    end
  end

  // First end cause wins and is held until reset
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      end_word_q <= '0;
    end else if (end_word_q == '0) begin
      if (end_hit_q) begin
        end_word_q <= hit_data_q;
      end else if (timeout) begin
        end_word_q <= '1;
      end
    end
  end

  // Extra stage toward the output
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      end_of_test_o <= '0;
    end else begin
      end_of_test_o <= end_word_q;
    end
  end

  assign end_hit_o = end_hit_q;

endmodule

/* source/commit_decoder.sv */
// Commit decoder that classifies each retirement and registers one trace record
module commit_decoder
  import rvfi_mon_pkg::*;
(
  input logic   clk_i,
  input logic   rst_ni,
  commit_if.snk commit,
  record_if.src rec
);

  insn_word_u      insn_w;
  insn_word_u      insn_shown;
  logic            fire;
  rec_kind_e       kind_d;
  logic [XLEN-1:0] data_d;
  logic [XLEN-1:0] addr_d;

  // FP destination from major opcode, OP-FP group, or compressed float load
  function automatic logic is_fp_dest(insn_word_u w);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < $size(FP_OPCODES); i++) begin
      if (w.full.opcode == FP_OPCODES[i]) hit = 1'b1;
    end
    if (w.full.opcode == OPC_OP_FP) begin
      for (int i = 0; i < $size(FP_NONDEST_FUNCT6); i++) begin
        if (w.full.funct6 == FP_NONDEST_FUNCT6[i]) hit = 1'b0;
      end
    end
    if (w.comp.op[0] == 1'b0 && w.comp.funct3 == C_FLOAD_FUNCT3) hit = 1'b1;
    return hit;
  endfunction

  assign insn_w = commit.insn;
  assign fire   = commit.valid | commit.trap;

  // Compressed words are shown as their 16 bits only
  always_comb begin
    insn_shown = insn_w;
    if (insn_w.comp.op != OP_UNCOMPRESSED) begin
      insn_shown.comp.unused = '0;
    end
  end

  always_comb begin
    kind_d = REC_PLAIN;
    data_d = '0;
    addr_d = '0;
    if (!commit.valid) begin
      // Only reaches the record when trap is set
      kind_d = REC_TRAP;
      data_d = commit.cause;
    end else if (is_fp_dest(insn_w)) begin
      kind_d = REC_FP;
      data_d = commit.rd_wdata;
    end else if (commit.rd_addr != '0) begin
      kind_d = REC_INT;
      data_d = commit.rd_wdata;
      if (commit.mem_rmask != '0) begin
        addr_d = commit.mem_addr;
      end
    end else if (commit.mem_wmask != '0) begin
      kind_d = REC_STORE;
      data_d = commit.mem_wdata;
      addr_d = commit.mem_addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rec.rec_valid <= 1'b0;
    end else begin
      rec.rec_valid <= fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      rec.kind    <= kind_d;
      rec.pc      <= commit.pc;
      rec.insn    <= insn_shown;
      rec.rd_addr <= commit.rd_addr;
      rec.data    <= data_d;
      rec.addr    <= addr_d;
      rec.intr    <= commit.intr;
    end
  end

endmodule

/* source/monitor_if.sv */
// Commit bundle and decoded trace record bundles between monitor blocks
interface commit_if import rvfi_mon_pkg::*; ();
  logic                  valid;
  logic                  trap;
  logic                  intr;
  logic [INSN_W-1:0]     insn;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       cause;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       rd_wdata;
  logic [XLEN-1:0]       mem_addr;
  logic [3:0]            mem_rmask;
  logic [3:0]            mem_wmask;
  logic [XLEN-1:0]       mem_wdata;

  modport src (output valid, trap, intr, insn, pc, cause, rd_addr, rd_wdata,
               mem_addr, mem_rmask, mem_wmask, mem_wdata);
  modport snk (input valid, trap, intr, insn, pc, cause, rd_addr, rd_wdata,
               mem_addr, mem_rmask, mem_wmask, mem_wdata);
endinterface

interface record_if import rvfi_mon_pkg::*; ();
  logic                  rec_valid;
  rec_kind_e             kind;
  logic [XLEN-1:0]       pc;
  logic [INSN_W-1:0]     insn;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       data;
  logic [XLEN-1:0]       addr;
  logic                  intr;

  modport src (output rec_valid, kind, pc, insn, rd_addr, data, addr, intr);
  modport snk (input rec_valid, kind, pc, insn, rd_addr, data, addr, intr);
endinterface

/* source/rvfi_mon_pkg.sv */
// Commit monitor shared widths, record classes and instruction decode constants
package rvfi_mon_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned INSN_W     = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Class of one trace record
  typedef enum logic [2:0] {
    REC_PLAIN = 3'd0,
    REC_INT   = 3'd1,
    REC_FP    = 3'd2,
    REC_STORE = 3'd3,
    REC_TRAP  = 3'd4
  } rec_kind_e;

  // One retired instruction word, read either as a full or as a compressed encoding
  typedef union packed {
    struct packed {
      logic [5:0]  funct6;
      logic [18:0] mid;
      logic [6:0]  opcode;
    } full;
    struct packed {
      logic [15:0] unused;
      logic [2:0]  funct3;
      logic [10:0] mid;
      logic [1:0]  op;
    } comp;
  } insn_word_u;

  // Low two bits of every 32-bit encoding
  localparam logic [1:0] OP_UNCOMPRESSED = 2'b11;

  // Major opcodes that target the FP register file
  localparam logic [6:0] OPC_LOAD_FP = 7'b0000111;
  localparam logic [6:0] OPC_MADD    = 7'b1000011;
  localparam logic [6:0] OPC_MSUB    = 7'b1000111;
  localparam logic [6:0] OPC_NMSUB   = 7'b1001011;
  localparam logic [6:0] OPC_NMADD   = 7'b1001111;
  localparam logic [6:0] OPC_OP_FP   = 7'b1010011;

  localparam logic [6:0] FP_OPCODES [6] = '{
    OPC_LOAD_FP,
    OPC_MADD,
    OPC_MSUB,
    OPC_NMSUB,
    OPC_NMADD,
    OPC_OP_FP
  };

  // OP-FP groups whose result lands in an integer register
  localparam logic [5:0] FP_NONDEST_FUNCT6 [3] = '{
    6'b111000,  // fmv.x.w and fclass
    6'b101000,  // feq, flt, fle
    6'b110000   // fcvt to integer
  };

  // Quadrant 0 and 2 float load for RV32
  localparam logic [2:0] C_FLOAD_FUNCT3 = 3'b011;

endpackage
